// ==== rtl/mtrap_pkg.sv ====
// Shared types, CSR addresses and fixed constants for the machine-mode trap unit.
`default_nettype none

package mtrap_pkg;

    // Data word.
    typedef logic [31:0] xlen_t;
    // CSR address.
    typedef logic [11:0] csr_addr_t;
    // Halfword instruction address, bits 31 to 1.
    typedef logic [31:1] pc_t;
    // Word-aligned trap vector, bits 31 to 2.
    typedef logic [31:2] tvec_t;
    // Interrupt or trap number.
    typedef logic [4:0] cause_t;
    // External interrupt lines 31 to 16.
    typedef logic [31:16] irq_vec_t;
    // Memory-mapped I/O address.
    typedef logic [31:0] mmio_addr_t;

    // Standard machine CSR addresses.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIMPID     = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Identity values.
    localparam xlen_t MVENDORID_VALUE  = 32'h0000_0000;
    localparam xlen_t MARCHID_VALUE    = 32'd37;
    // Version 2.0.0, major in bits 15:8.
    localparam xlen_t MIMPID_VALUE     = 32'h0000_0200;
    localparam xlen_t MCONFIGPTR_VALUE = 32'h0000_0000;

    // Only M-mode exists, so MPP is hardwired.
    localparam logic [1:0] MPP_MACHINE = 2'd3;

    // mstatus field positions.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // Machine timer interrupt number.
    localparam cause_t TIMER_IRQ_NO = 5'd7;

    // Edges MIE must be held before interrupts may fire.
    localparam int MIE_DELAY = 2;

    // Timer register offsets from the timer base.
    localparam mmio_addr_t MTIME_OFFSET    = 32'h0000_0000;
    localparam mmio_addr_t MTIMECMP_OFFSET = 32'h0000_0008;

endpackage

`default_nettype wire

// ==== rtl/irq_prioritizer.sv ====
// Latches interrupt lines, masks them with mie and picks the lowest pending cause.
`timescale 1ns/1ps
`default_nettype none

module irq_prioritizer (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire mtrap_pkg::irq_vec_t irq,
    input  wire logic             timer_irq,
    input  wire mtrap_pkg::xlen_t csr_mie,
    output mtrap_pkg::xlen_t      irq_ip,
    output logic                  irq_pending,
    output mtrap_pkg::cause_t     irq_cause
);

    // Pending interrupts that are also enabled.
    mtrap_pkg::xlen_t irq_masked;

    // One register stage on every line.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_ip <= '0;
        end else begin
            irq_ip                          <= '0;
            irq_ip[31:16]                   <= irq;
            irq_ip[mtrap_pkg::TIMER_IRQ_NO] <= timer_irq;
        end
    end

    assign irq_masked  = irq_ip & csr_mie;
    assign irq_pending = |irq_masked;

    // Scan downward so the lowest set bit is the last one written.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_masked[i]) begin
                irq_cause = mtrap_pkg::cause_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/trap_dispatch.sv ====
// Chooses between interrupt, trap and mret each cycle and forms the fetch redirect.
`timescale 1ns/1ps
`default_nettype none

module trap_dispatch (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              retire_valid,
    input  wire mtrap_pkg::pc_t    retire_pc,
    input  wire logic              retire_trap,
    input  wire mtrap_pkg::cause_t retire_cause,
    input  wire logic              mret,
    input  wire logic              irq_pending,
    input  wire mtrap_pkg::cause_t irq_cause,
    input  wire logic              status_mie,
    input  wire mtrap_pkg::tvec_t  mtvec,
    input  wire mtrap_pkg::pc_t    mepc,
    output logic                   exc_take,
    output logic                   exc_is_irq,
    output mtrap_pkg::cause_t      exc_cause,
    output mtrap_pkg::pc_t         exc_epc,
    output logic                   ret_take,
    output logic                   trap_taken,
    output logic                   trap_is_irq,
    output logic                   redirect_valid,
    output mtrap_pkg::pc_t         redirect_pc
);

    // MIE sampled on the last few edges.
    logic [mtrap_pkg::MIE_DELAY-1:0] mie_hist;
    // Interrupts allowed this cycle.
    logic irq_allowed;
    // Interrupt and trap taken on this retire.
    logic irq_take;
    logic sync_take;

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= {mie_hist[mtrap_pkg::MIE_DELAY-2:0], status_mie};
        end
    end

    // A freshly set MIE must settle before it opens the gate.
    assign irq_allowed = (&mie_hist) && status_mie;

    // Interrupts win over a trapping instruction.
    assign irq_take  = retire_valid && irq_pending && irq_allowed;
    assign sync_take = retire_valid && retire_trap && !irq_take;

    assign exc_take   = irq_take || sync_take;
    assign exc_is_irq = irq_take;
    assign exc_cause  = irq_take ? irq_cause : retire_cause;
    // The retiring instruction is where execution resumes.
    assign exc_epc    = retire_pc;

    // A trap in the same cycle cancels mret.
    assign ret_take = mret && !exc_take;

    assign trap_taken  = exc_take;
    assign trap_is_irq = exc_is_irq;

    assign redirect_valid = exc_take || ret_take;
    // mtvec is word aligned, so append one zero for the halfword address.
    assign redirect_pc    = exc_take ? {mtvec, 1'b0} : mepc;

endmodule

`default_nettype wire

// ==== rtl/m_csr_file.sv ====
// Machine CSR storage with combinational reads and trap, write and mret updates.
`timescale 1ns/1ps
`default_nettype none

module m_csr_file #(
    // Hart number returned by mhartid.
    parameter mtrap_pkg::xlen_t hartid = '0
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire mtrap_pkg::csr_addr_t csr_addr,
    input  wire logic                csr_we,
    input  wire mtrap_pkg::xlen_t    csr_wdata,
    output mtrap_pkg::xlen_t         csr_rdata,
    output logic                     csr_exists,
    output logic                     csr_rdonly,
    input  wire mtrap_pkg::xlen_t    irq_ip,
    input  wire logic                exc_take,
    input  wire logic                exc_is_irq,
    input  wire mtrap_pkg::cause_t   exc_cause,
    input  wire mtrap_pkg::pc_t      exc_epc,
    input  wire logic                ret_take,
    output logic                     status_mie,
    output mtrap_pkg::xlen_t         csr_mie,
    output mtrap_pkg::tvec_t         mtvec,
    output mtrap_pkg::pc_t           mepc
);

    // mstatus.MPIE.
    logic status_mpie;
    // mscratch.
    mtrap_pkg::xlen_t mscratch;
    // mcause split into flag and number.
    logic              mcause_int;
    mtrap_pkg::cause_t mcause_no;
    // Assembled mstatus.
    mtrap_pkg::xlen_t mstatus_val;

    always_comb begin
        mstatus_val = '0;
        mstatus_val[mtrap_pkg::MSTATUS_MIE_BIT]  = status_mie;
        mstatus_val[mtrap_pkg::MSTATUS_MPIE_BIT] = status_mpie;
        mstatus_val[mtrap_pkg::MSTATUS_MPP_LSB +: 2] = mtrap_pkg::MPP_MACHINE;
    end

    // Top two address bits of 11 mark a read-only CSR.
    assign csr_rdonly = (csr_addr[11:10] == 2'b11);

    // Read mux.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdata  = '0;
        case (csr_addr)
            mtrap_pkg::CSR_MSTATUS:    csr_rdata = mstatus_val;
            mtrap_pkg::CSR_MIE:        csr_rdata = csr_mie;
            mtrap_pkg::CSR_MTVEC:      csr_rdata = {mtvec, 2'b00};
            mtrap_pkg::CSR_MIP:        csr_rdata = irq_ip & csr_mie;
            mtrap_pkg::CSR_MSCRATCH:   csr_rdata = mscratch;
            mtrap_pkg::CSR_MEPC:       csr_rdata = {mepc, 1'b0};
            mtrap_pkg::CSR_MCAUSE:     csr_rdata = {mcause_int, 26'b0, mcause_no};
            // Delegation and trap value are not implemented.
            mtrap_pkg::CSR_MEDELEG,
            mtrap_pkg::CSR_MIDELEG,
            mtrap_pkg::CSR_MSTATUSH,
            mtrap_pkg::CSR_MTVAL:      csr_rdata = '0;
            mtrap_pkg::CSR_MVENDORID:  csr_rdata = mtrap_pkg::MVENDORID_VALUE;
            mtrap_pkg::CSR_MARCHID:    csr_rdata = mtrap_pkg::MARCHID_VALUE;
            mtrap_pkg::CSR_MIMPID:     csr_rdata = mtrap_pkg::MIMPID_VALUE;
            mtrap_pkg::CSR_MHARTID:    csr_rdata = hartid;
            mtrap_pkg::CSR_MCONFIGPTR: csr_rdata = mtrap_pkg::MCONFIGPTR_VALUE;
            default:                   csr_exists = 1'b0;
        endcase
    end

    // Updates: trap first, then CSR write, then mret.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            csr_mie     <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause_int  <= 1'b0;
            mcause_no   <= '0;
        end else if (exc_take) begin
            // Stack MIE and mask further interrupts.
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            mepc        <= exc_epc;
            mcause_int  <= exc_is_irq;
            mcause_no   <= exc_cause;
        end else if (csr_we) begin
            case (csr_addr)
                mtrap_pkg::CSR_MSTATUS: begin
                    status_mie  <= csr_wdata[mtrap_pkg::MSTATUS_MIE_BIT];
                    status_mpie <= csr_wdata[mtrap_pkg::MSTATUS_MPIE_BIT];
                end
                mtrap_pkg::CSR_MIE:      csr_mie  <= csr_wdata;
                mtrap_pkg::CSR_MTVEC:    mtvec    <= csr_wdata[31:2];
                mtrap_pkg::CSR_MSCRATCH: mscratch <= csr_wdata;
                mtrap_pkg::CSR_MEPC:     mepc     <= csr_wdata[31:1];
                mtrap_pkg::CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[31];
                    mcause_no  <= csr_wdata[4:0];
                end
                // Read-only and zero CSRs drop the write.
                default: ;
            endcase
        end else if (ret_take) begin
            // Return restores the stacked enable.
            status_mie <= status_mpie;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/machine_timer.sv ====
// Memory-mapped mtime and mtimecmp registers that raise the machine timer interrupt.
`timescale 1ns/1ps
`default_nettype none

module machine_timer #(
    // Address of mtime low word.
    parameter mtrap_pkg::mmio_addr_t timer_base = 32'hff00_0000
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mtrap_pkg::mmio_addr_t mmio_addr,
    input  wire logic                  mmio_we,
    input  wire mtrap_pkg::xlen_t      mmio_wdata,
    output logic                       mmio_hit,
    output mtrap_pkg::xlen_t           mmio_rdata,
    output logic                       timer_irq
);

    // Word addresses of the four halves.
    localparam mtrap_pkg::mmio_addr_t TIME_LO = timer_base + mtrap_pkg::MTIME_OFFSET;
    localparam mtrap_pkg::mmio_addr_t TIME_HI = TIME_LO + 32'd4;
    localparam mtrap_pkg::mmio_addr_t CMP_LO  = timer_base + mtrap_pkg::MTIMECMP_OFFSET;
    localparam mtrap_pkg::mmio_addr_t CMP_HI  = CMP_LO + 32'd4;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    // Address decode.
    logic sel_time_lo;
    logic sel_time_hi;
    logic sel_cmp_lo;
    logic sel_cmp_hi;

    assign sel_time_lo = (mmio_addr == TIME_LO);
    assign sel_time_hi = (mmio_addr == TIME_HI);
    assign sel_cmp_lo  = (mmio_addr == CMP_LO);
    assign sel_cmp_hi  = (mmio_addr == CMP_HI);
    assign mmio_hit    = sel_time_lo || sel_time_hi || sel_cmp_lo || sel_cmp_hi;

    always_comb begin
        mmio_rdata = '0;
        if (sel_time_lo) mmio_rdata = mtime[31:0];
        if (sel_time_hi) mmio_rdata = mtime[63:32];
        if (sel_cmp_lo)  mmio_rdata = mtimecmp[31:0];
        if (sel_cmp_hi)  mmio_rdata = mtimecmp[63:32];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime     <= '0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            // A write to mtime replaces this cycle's increment.
            if (mmio_we && sel_time_lo) begin
                mtime <= {mtime[63:32], mmio_wdata};
            end else if (mmio_we && sel_time_hi) begin
                mtime <= {mmio_wdata, mtime[31:0]};
            end else begin
                mtime <= mtime + 64'd1;
            end
            if (mmio_we && sel_cmp_lo) begin
                mtimecmp[31:0] <= mmio_wdata;
            end
            if (mmio_we && sel_cmp_hi) begin
                mtimecmp[63:32] <= mmio_wdata;
            end
            // Registered compare, one cycle behind mtime.
            timer_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/trap_unit_top.sv ====
// Top level of the trap and interrupt controller; connects CSRs, dispatch, IRQs and timer.
`timescale 1ns/1ps
`default_nettype none

module trap_unit_top #(
    // Value of mhartid.
    parameter mtrap_pkg::xlen_t      hartid     = '0,
    // Base address of the timer registers.
    parameter mtrap_pkg::mmio_addr_t timer_base = 32'hff00_0000
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Retiring instruction.
    input  wire logic                  retire_valid,
    input  wire mtrap_pkg::pc_t        retire_pc,
    input  wire logic                  retire_trap,
    input  wire mtrap_pkg::cause_t     retire_cause,
    input  wire logic                  mret,
    // CSR access.
    input  wire mtrap_pkg::csr_addr_t  csr_addr,
    input  wire logic                  csr_we,
    input  wire mtrap_pkg::xlen_t      csr_wdata,
    output mtrap_pkg::xlen_t           csr_rdata,
    output logic                       csr_exists,
    output logic                       csr_rdonly,
    // Timer registers.
    input  wire mtrap_pkg::mmio_addr_t mmio_addr,
    input  wire logic                  mmio_we,
    input  wire mtrap_pkg::xlen_t      mmio_wdata,
    output logic                       mmio_hit,
    output mtrap_pkg::xlen_t           mmio_rdata,
    // External interrupt lines.
    input  wire mtrap_pkg::irq_vec_t   irq,
    // Fetch redirect.
    output logic                       trap_taken,
    output logic                       trap_is_irq,
    output logic                       redirect_valid,
    output mtrap_pkg::pc_t             redirect_pc
);

    logic              timer_irq;
    mtrap_pkg::xlen_t  irq_ip;
    logic              irq_pending;
    mtrap_pkg::cause_t irq_cause;
    mtrap_pkg::xlen_t  csr_mie;
    logic              status_mie;
    mtrap_pkg::tvec_t  mtvec;
    mtrap_pkg::pc_t    mepc;
    // Trap and return updates into the CSRs.
    logic              exc_take;
    logic              exc_is_irq;
    mtrap_pkg::cause_t exc_cause;
    mtrap_pkg::pc_t    exc_epc;
    logic              ret_take;

    irq_prioritizer u_irq (
        .clk(clk), .rst(rst), .irq(irq), .timer_irq(timer_irq), .csr_mie(csr_mie),
        .irq_ip(irq_ip), .irq_pending(irq_pending), .irq_cause(irq_cause)
    );

    trap_dispatch u_dispatch (
        .clk(clk), .rst(rst), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_trap(retire_trap), .retire_cause(retire_cause), .mret(mret),
        .irq_pending(irq_pending), .irq_cause(irq_cause), .status_mie(status_mie),
        .mtvec(mtvec), .mepc(mepc), .exc_take(exc_take), .exc_is_irq(exc_is_irq),
        .exc_cause(exc_cause), .exc_epc(exc_epc), .ret_take(ret_take),
        .trap_taken(trap_taken), .trap_is_irq(trap_is_irq),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    m_csr_file #(.hartid(hartid)) u_csr (
        .clk(clk), .rst(rst), .csr_addr(csr_addr), .csr_we(csr_we),
        .csr_wdata(csr_wdata), .csr_rdata(csr_rdata), .csr_exists(csr_exists),
        .csr_rdonly(csr_rdonly), .irq_ip(irq_ip), .exc_take(exc_take),
        .exc_is_irq(exc_is_irq), .exc_cause(exc_cause), .exc_epc(exc_epc),
        .ret_take(ret_take), .status_mie(status_mie), .csr_mie(csr_mie),
        .mtvec(mtvec), .mepc(mepc)
    );

    machine_timer #(.timer_base(timer_base)) u_timer (
        .clk(clk), .rst(rst), .mmio_addr(mmio_addr), .mmio_we(mmio_we),
        .mmio_wdata(mmio_wdata), .mmio_hit(mmio_hit), .mmio_rdata(mmio_rdata),
        .timer_irq(timer_irq)
    );

endmodule

`default_nettype wire

// ==== verif/clock_gen.sv ====
// Testbench clock and synchronous reset source; instantiate once in the testbench top.
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    // Half of the 8 ns clock period.
    parameter int half_period  = 4,
    // Rising edges with reset held high.
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release on a clock edge so the DUT sees a clean synchronous reset.
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/tb_trap_unit.sv ====
// Table-driven testbench for trap_unit_top; each table row is one clock cycle of stimulus.
`timescale 1ns/1ps
`default_nettype none

module tb_trap_unit;

    localparam mtrap_pkg::xlen_t      HARTID     = 32'd5;
    localparam mtrap_pkg::mmio_addr_t TIMER_BASE = 32'h0200_0000;
    localparam mtrap_pkg::mmio_addr_t TIME_LO    = TIMER_BASE + mtrap_pkg::MTIME_OFFSET;
    localparam mtrap_pkg::mmio_addr_t CMP_LO     = TIMER_BASE + mtrap_pkg::MTIMECMP_OFFSET;
    localparam mtrap_pkg::mmio_addr_t CMP_HI     = CMP_LO + 32'd4;

    // Row kinds.
    localparam logic [2:0] OP_CSR_WR   = 3'd0;
    localparam logic [2:0] OP_CSR_CHK  = 3'd1;
    localparam logic [2:0] OP_MMIO_WR  = 3'd2;
    localparam logic [2:0] OP_MMIO_CHK = 3'd3;
    localparam logic [2:0] OP_SET_IRQ  = 3'd4;
    localparam logic [2:0] OP_RETIRE   = 3'd5;
    localparam logic [2:0] OP_TRAP     = 3'd6;
    localparam logic [2:0] OP_MRET     = 3'd7;

    // Address holds the CSR, MMIO address or cause; data holds the value or PC.
    // rel adds the captured mtime on MMIO writes, and captures on MMIO checks.
    // exp_a to exp_c hold exists and rdonly, hit, or the three trap outputs.
    typedef struct packed {
        logic [2:0]       op;
        mtrap_pkg::xlen_t addr;
        mtrap_pkg::xlen_t data;
        logic             rel;
        mtrap_pkg::xlen_t exp_data;
        logic             exp_a;
        logic             exp_b;
        logic             exp_c;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  retire_valid;
    mtrap_pkg::pc_t        retire_pc;
    logic                  retire_trap;
    mtrap_pkg::cause_t     retire_cause;
    logic                  mret;
    mtrap_pkg::csr_addr_t  csr_addr;
    logic                  csr_we;
    mtrap_pkg::xlen_t      csr_wdata;
    mtrap_pkg::xlen_t      csr_rdata;
    logic                  csr_exists;
    logic                  csr_rdonly;
    mtrap_pkg::mmio_addr_t mmio_addr;
    logic                  mmio_we;
    mtrap_pkg::xlen_t      mmio_wdata;
    logic                  mmio_hit;
    mtrap_pkg::xlen_t      mmio_rdata;
    mtrap_pkg::irq_vec_t   irq;
    logic                  trap_taken;
    logic                  trap_is_irq;
    logic                  redirect_valid;
    mtrap_pkg::pc_t        redirect_pc;

    row_t             rows[$];
    int               seed     = 73133;
    int               cycles   = 0;
    int               limit    = 0;
    mtrap_pkg::xlen_t captured = '0;

    clock_gen #(.half_period(4), .reset_cycles(5)) u_clk (.clk(clk), .rst(rst));

    trap_unit_top #(.hartid(HARTID), .timer_base(TIMER_BASE)) dut (
        .clk(clk), .rst(rst), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_trap(retire_trap), .retire_cause(retire_cause), .mret(mret),
        .csr_addr(csr_addr), .csr_we(csr_we), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .csr_exists(csr_exists), .csr_rdonly(csr_rdonly),
        .mmio_addr(mmio_addr), .mmio_we(mmio_we), .mmio_wdata(mmio_wdata),
        .mmio_hit(mmio_hit), .mmio_rdata(mmio_rdata), .irq(irq),
        .trap_taken(trap_taken), .trap_is_irq(trap_is_irq),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_xlen(input string name, input mtrap_pkg::xlen_t got,
                              input mtrap_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_pc(input string name, input mtrap_pkg::pc_t got,
                            input mtrap_pkg::pc_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_cause(input string name, input mtrap_pkg::cause_t got,
                               input mtrap_pkg::cause_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // Expected mstatus with MPP fixed at machine mode.
    function automatic mtrap_pkg::xlen_t mstatus_expect(input logic mie, input logic mpie);
        mtrap_pkg::xlen_t v;
        v = '0;
        v[mtrap_pkg::MSTATUS_MIE_BIT]  = mie;
        v[mtrap_pkg::MSTATUS_MPIE_BIT] = mpie;
        v[12:11] = 2'b11;
        return v;
    endfunction

    task automatic push_row(input logic [2:0] op, input mtrap_pkg::xlen_t addr,
                            input mtrap_pkg::xlen_t data, input logic rel,
                            input mtrap_pkg::xlen_t exp_data, input logic a,
                            input logic b, input logic c);
        rows.push_back('{op, addr, data, rel, exp_data, a, b, c});
    endtask

    task automatic csr_write_step(input mtrap_pkg::csr_addr_t a, input mtrap_pkg::xlen_t d);
        push_row(OP_CSR_WR, 32'(a), d, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic csr_check_step(input mtrap_pkg::csr_addr_t a, input mtrap_pkg::xlen_t e,
                                  input logic exists, input logic rdonly);
        push_row(OP_CSR_CHK, 32'(a), '0, 1'b0, e, exists, rdonly, 1'b0);
    endtask

    // Retire rows carry the PC in data and the cause in addr.
    task automatic retire_step(input logic [2:0] op, input mtrap_pkg::xlen_t pc,
                               input mtrap_pkg::xlen_t cause, input mtrap_pkg::xlen_t target,
                               input logic taken, input logic is_irq, input logic redirect);
        push_row(op, cause, pc, 1'b0, target, taken, is_irq, redirect);
    endtask

    // Cycle counter bounds the run.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            stop_with_failure();
        end
    end

    initial begin
        row_t             row;
        mtrap_pkg::xlen_t scratch_data;
        mtrap_pkg::xlen_t mie_data;
        mtrap_pkg::xlen_t tvec_data;
        mtrap_pkg::xlen_t epc_data;
        mtrap_pkg::xlen_t cause_data;
        mtrap_pkg::xlen_t tvec_target;
        retire_valid = 1'b0;
        retire_pc    = '0;
        retire_trap  = 1'b0;
        retire_cause = '0;
        mret         = 1'b0;
        csr_addr     = '0;
        csr_we       = 1'b0;
        csr_wdata    = '0;
        mmio_addr    = '0;
        mmio_we      = 1'b0;
        mmio_wdata   = '0;
        irq          = '0;
        scratch_data = $random(seed);
        mie_data     = $random(seed);
        tvec_data    = $random(seed);
        epc_data     = $random(seed);
        cause_data   = $random(seed);
        // Trap target is mtvec with its low two bits dropped.
        tvec_target  = tvec_data & 32'hffff_fffc;

        // Reset values and identity CSRs.
        csr_check_step(mtrap_pkg::CSR_MSTATUS, mstatus_expect(1'b0, 1'b0), 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MIE, '0, 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MEPC, '0, 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MCAUSE, '0, 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MEDELEG, '0, 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MHARTID, HARTID, 1'b1, 1'b1);
        csr_check_step(mtrap_pkg::CSR_MARCHID, 32'd37, 1'b1, 1'b1);
        // Version 2.0.0 with the major number in bits 15:8.
        csr_check_step(mtrap_pkg::CSR_MIMPID, 32'h0000_0200, 1'b1, 1'b1);
        csr_check_step(mtrap_pkg::CSR_MVENDORID, '0, 1'b1, 1'b1);
        csr_check_step(mtrap_pkg::CSR_MCONFIGPTR, '0, 1'b1, 1'b1);
        csr_check_step(12'h7c0, '0, 1'b0, 1'b0);
        push_row(OP_MMIO_CHK, CMP_HI, '0, 1'b0, 32'hffff_ffff, 1'b1, 1'b0, 1'b0);
        push_row(OP_MMIO_CHK, TIMER_BASE + 32'h10, '0, 1'b0, '0, 1'b0, 1'b0, 1'b0);

        // Write and read back random values.
        csr_write_step(mtrap_pkg::CSR_MSCRATCH, scratch_data);
        csr_check_step(mtrap_pkg::CSR_MSCRATCH, scratch_data, 1'b1, 1'b0);
        csr_write_step(mtrap_pkg::CSR_MIE, mie_data);
        csr_check_step(mtrap_pkg::CSR_MIE, mie_data, 1'b1, 1'b0);
        csr_write_step(mtrap_pkg::CSR_MTVEC, tvec_data);
        csr_check_step(mtrap_pkg::CSR_MTVEC, tvec_target, 1'b1, 1'b0);
        csr_write_step(mtrap_pkg::CSR_MEPC, epc_data);
        csr_check_step(mtrap_pkg::CSR_MEPC, epc_data & 32'hffff_fffe, 1'b1, 1'b0);
        csr_write_step(mtrap_pkg::CSR_MCAUSE, cause_data);
        csr_check_step(mtrap_pkg::CSR_MCAUSE, cause_data & 32'h8000_001f, 1'b1, 1'b0);

        // Synchronous trap with interrupts masked off in mie.
        csr_write_step(mtrap_pkg::CSR_MIE, '0);
        csr_write_step(mtrap_pkg::CSR_MSTATUS, 32'h0000_0008);
        csr_check_step(mtrap_pkg::CSR_MSTATUS, mstatus_expect(1'b1, 1'b0), 1'b1, 1'b0);
        retire_step(OP_TRAP, 32'h1000_0040, 32'd2, tvec_target, 1'b1, 1'b0, 1'b1);
        csr_check_step(mtrap_pkg::CSR_MEPC, 32'h1000_0040, 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MCAUSE, 32'd2, 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MSTATUS, mstatus_expect(1'b0, 1'b1), 1'b1, 1'b0);

        // Return to the saved PC.
        retire_step(OP_MRET, '0, '0, 32'h1000_0040, 1'b0, 1'b0, 1'b1);
        csr_check_step(mtrap_pkg::CSR_MSTATUS, mstatus_expect(1'b1, 1'b1), 1'b1, 1'b0);

        // Two external lines pending and the lowest number wins.
        csr_write_step(mtrap_pkg::CSR_MIE, (32'd1 << 17) | (32'd1 << 20));
        push_row(OP_SET_IRQ, '0, (32'd1 << 17) | (32'd1 << 20), 1'b0, '0, 1'b0, 1'b0, 1'b0);
        repeat (3) begin
            csr_check_step(mtrap_pkg::CSR_MIP, (32'd1 << 17) | (32'd1 << 20), 1'b1, 1'b0);
        end
        retire_step(OP_RETIRE, 32'h2000_0010, '0, tvec_target, 1'b1, 1'b1, 1'b1);
        csr_check_step(mtrap_pkg::CSR_MCAUSE, 32'h8000_0011, 1'b1, 1'b0);
        csr_check_step(mtrap_pkg::CSR_MEPC, 32'h2000_0010, 1'b1, 1'b0);

        // Timer fires a few cycles after mtimecmp is set near mtime.
        push_row(OP_SET_IRQ, '0, '0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        csr_write_step(mtrap_pkg::CSR_MIE, (32'd1 << 7) | (32'd1 << 16));
        csr_write_step(mtrap_pkg::CSR_MSTATUS, 32'h0000_0008);
        push_row(OP_MMIO_CHK, TIME_LO, '0, 1'b1, '0, 1'b1, 1'b0, 1'b0);
        push_row(OP_MMIO_WR, CMP_HI, '0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        push_row(OP_MMIO_WR, CMP_LO, 32'd4, 1'b1, '0, 1'b0, 1'b0, 1'b0);
        push_row(OP_SET_IRQ, '0, 32'd1 << 16, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        repeat (10) begin
            csr_check_step(mtrap_pkg::CSR_MSTATUS, mstatus_expect(1'b1, 1'b0), 1'b1, 1'b0);
        end
        csr_check_step(mtrap_pkg::CSR_MIP, (32'd1 << 7) | (32'd1 << 16), 1'b1, 1'b0);
        retire_step(OP_RETIRE, 32'h3000_0020, '0, tvec_target, 1'b1, 1'b1, 1'b1);
        csr_check_step(mtrap_pkg::CSR_MCAUSE, 32'h8000_0007, 1'b1, 1'b0);

        limit = rows.size() * 8 + 50;
        wait (rst === 1'b0);

        for (int i = 0; i < rows.size(); i++) begin
            row = rows[i];
            @(posedge clk);
            // Strobes last one cycle.
            csr_we       <= 1'b0;
            mmio_we      <= 1'b0;
            retire_valid <= 1'b0;
            retire_trap  <= 1'b0;
            mret         <= 1'b0;
            case (row.op)
                OP_CSR_WR: begin
                    csr_addr  <= row.addr[11:0];
                    csr_we    <= 1'b1;
                    csr_wdata <= row.data;
                end
                OP_CSR_CHK:  csr_addr <= row.addr[11:0];
                OP_MMIO_WR: begin
                    mmio_addr  <= row.addr;
                    mmio_we    <= 1'b1;
                    mmio_wdata <= row.rel ? row.data + captured : row.data;
                end
                OP_MMIO_CHK: mmio_addr <= row.addr;
                OP_SET_IRQ:  irq <= row.data[31:16];
                OP_MRET:     mret <= 1'b1;
                default: begin
                    retire_valid <= 1'b1;
                    retire_trap  <= (row.op == OP_TRAP);
                    retire_pc    <= row.data[31:1];
                    retire_cause <= row.addr[4:0];
                end
            endcase
            // Combinational replies are settled by mid-cycle.
            @(negedge clk);
            case (row.op)
                OP_CSR_CHK: begin
                    if (row.addr[11:0] == mtrap_pkg::CSR_MCAUSE) begin
                        check_flag("mcause.interrupt", csr_rdata[31], row.exp_data[31]);
                        check_cause("mcause.code", csr_rdata[4:0], row.exp_data[4:0]);
                    end
                    check_xlen("csr_rdata", csr_rdata, row.exp_data);
                    check_flag("csr_exists", csr_exists, row.exp_a);
                    check_flag("csr_rdonly", csr_rdonly, row.exp_b);
                end
                OP_MMIO_CHK: begin
                    check_flag("mmio_hit", mmio_hit, row.exp_a);
                    if (row.rel) begin
                        captured = mmio_rdata;
                    end else begin
                        check_xlen("mmio_rdata", mmio_rdata, row.exp_data);
                    end
                end
                OP_RETIRE, OP_TRAP, OP_MRET: begin
                    check_flag("trap_taken", trap_taken, row.exp_a);
                    check_flag("trap_is_irq", trap_is_irq, row.exp_b);
                    check_flag("redirect_valid", redirect_valid, row.exp_c);
                    check_pc("redirect_pc", redirect_pc, row.exp_data[31:1]);
                end
                default: ;
            endcase
            // No redirect without a retire or mret strobe.
            if (row.op != OP_RETIRE && row.op != OP_TRAP && row.op != OP_MRET) begin
                check_flag("trap_taken", trap_taken, 1'b0);
                check_flag("redirect_valid", redirect_valid, 1'b0);
            end
        end

        @(posedge clk);
        csr_we       <= 1'b0;
        mmio_we      <= 1'b0;
        retire_valid <= 1'b0;
        mret         <= 1'b0;
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/mtrap_pkg.sv
rtl/irq_prioritizer.sv
rtl/trap_dispatch.sv
rtl/m_csr_file.sv
rtl/machine_timer.sv
rtl/trap_unit_top.sv
verif/clock_gen.sv
verif/tb_trap_unit.sv
